// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= terminal_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/term_config.svh ====
`ifndef TERM_CONFIG_SVH
`define TERM_CONFIG_SVH

// Screen geometry
`define TERM_COL_BITS 6                                  // 64 columns
`define TERM_ROW_BITS 5                                  // 32 rows
`define TERM_ADDR_BITS (`TERM_COL_BITS + `TERM_ROW_BITS) // Flat cell index width
`define TERM_COLS (1 << `TERM_COL_BITS)                  // Active cells per line
`define TERM_ROWS (1 << `TERM_ROW_BITS)                  // Active lines per frame

// Raster blanking, in cells and in lines
`define TERM_H_BLANK 8                                   // Blank cells after each row
`define TERM_V_BLANK 2                                   // Blank lines after each frame

// Serial line
`define TERM_CLKS_PER_BIT 16                             // UART bit time in clocks

// Bell shown as reverse video for this many clocks
`define TERM_BELL_CYCLES 300

`endif

// ==== rtl/term_control.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "term_config.svh"

module term_control (
    input  wire               i_clk,
    input  wire               i_reset,
    input  wire               i_show_ctrl,       // Store control codes as glyphs
    input  wire               i_valid,           // Byte from receiver
    input  wire term_pkg::char_t i_char,
    output logic              o_ready,
    output term_pkg::vram_wr_t o_wr,             // Screen write port
    output logic              o_bell             // Reverse video request
);

    import term_pkg::*;

    localparam int BELL_BITS = $clog2(`TERM_BELL_CYCLES + 1);
    localparam int CLR_BITS  = `TERM_ADDR_BITS + 1; // Top bit marks sweep done

    typedef enum logic {
        S_IDLE,                                  // Accept bytes
        S_CLEAR                                  // Sweep spaces over the screen
    } ctrl_state_t;

    ctrl_state_t          state;
    screen_addr_u         cursor;                // Next print position
    logic [CLR_BITS-1:0]  clr_cnt;               // Next cell of the sweep
    logic [BELL_BITS-1:0] bell_cnt;              // Remaining bell clocks
    logic                 accept;
    logic                 is_print;              // 0x20 to 0x7E
    logic                 store;                 // Byte goes to the screen

    assign o_ready  = (state == S_IDLE);
    assign accept   = i_valid && o_ready;
    assign is_print = (i_char >= CH_SPACE) && (i_char <= CH_TILDE);
    assign store    = is_print || i_show_ctrl;
    assign o_bell   = (bell_cnt != '0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state      <= S_IDLE;
            cursor.raw <= '0;
            clr_cnt    <= '0;
            bell_cnt   <= '0;
            o_wr.we    <= 1'b0;
        end else begin
            o_wr.we <= 1'b0;                     // Strobe lasts one clock
            if (o_bell) bell_cnt <= bell_cnt - 1'b1;
            case (state)
                S_IDLE: begin
                    if (accept && store) begin
                        o_wr.we    <= 1'b1;
                        o_wr.addr  <= cursor;
                        o_wr.data  <= i_char;
                        cursor.raw <= cursor.raw + 1'b1; // Col 63 rolls into next row
                    end else if (accept) begin
                        case (i_char)
                            CH_CR: cursor.pos.col <= '0;
                            CH_LF: cursor.pos.row <= cursor.pos.row + 1'b1; // Row 31 wraps
                            CH_BS: begin
                                if (cursor.pos.col != '0) begin
                                    cursor.pos.col <= cursor.pos.col - 1'b1;
                                end
                            end
                            CH_BEL: bell_cnt <= BELL_BITS'(`TERM_BELL_CYCLES); // Restart
                            CH_FF: begin
                                state         <= S_CLEAR;
                                o_wr.we       <= 1'b1;   // Cell 0 right away
                                o_wr.addr.raw <= '0;
                                o_wr.data     <= CH_SPACE;
                                clr_cnt       <= CLR_BITS'(1);
                            end
                            default: ;                   // Other codes ignored
                        endcase
                    end
                end
                S_CLEAR: begin
                    if (clr_cnt[CLR_BITS-1]) begin       // Last cell written
                        state      <= S_IDLE;
                        cursor.raw <= '0;                // Home
                    end else begin
                        o_wr.we       <= 1'b1;
                        o_wr.addr.raw <= clr_cnt[CLR_BITS-2:0];
                        o_wr.data     <= CH_SPACE;
                        clr_cnt       <= clr_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/term_pkg.sv ====
`default_nettype none

`include "term_config.svh"

package term_pkg;

    typedef logic [7:0] char_t;                      // One character code

    // Codes the control block acts on
    localparam char_t CH_BEL   = 8'h07;              // Bell
    localparam char_t CH_BS    = 8'h08;              // Backspace
    localparam char_t CH_LF    = 8'h0A;              // Line feed
    localparam char_t CH_FF    = 8'h0C;              // Form feed, clears screen
    localparam char_t CH_CR    = 8'h0D;              // Carriage return
    localparam char_t CH_SPACE = 8'h20;              // First printable code
    localparam char_t CH_TILDE = 8'h7E;              // Last printable code

    typedef struct packed {
        logic [`TERM_ROW_BITS-1:0] row;              // Upper address bits
        logic [`TERM_COL_BITS-1:0] col;              // Lower address bits
    } screen_pos_t;

    // Same 11 bits seen as memory index or as row/column
    typedef union packed {
        logic [`TERM_ADDR_BITS-1:0] raw;             // Flat index into VRAM
        screen_pos_t                pos;             // Cursor view
    } screen_addr_u;

    typedef struct packed {
        logic         we;                            // Write strobe
        screen_addr_u addr;                          // Target cell
        char_t        data;                          // Code to store
    } vram_wr_t;                                     // 20 bits

endpackage

`default_nettype wire

// ==== rtl/terminal_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "term_config.svh"

module terminal_top (
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_rxd,           // Serial from host
    input  wire                     i_show_ctrl,     // Control codes as glyphs
    output video_pkg::video_cell_t  o_video          // One cell per clock
);

    import term_pkg::*;

    logic                        byte_valid;         // Receiver has a byte
    char_t                       byte_data;
    logic                        byte_ready;         // Low during screen clear
    vram_wr_t                    vram_wr;            // Control to VRAM
    logic [`TERM_ADDR_BITS-1:0]  rd_addr;            // Scan to VRAM
    char_t                       rd_data;            // VRAM to scan
    logic                        bell;               // Reverse video level

    uart_rx rx0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rxd       (i_rxd),
        .o_valid     (byte_valid),
        .o_data      (byte_data),
        .i_ready     (byte_ready)
    );

    term_control ctrl0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_show_ctrl (i_show_ctrl),
        .i_valid     (byte_valid),
        .i_char      (byte_data),
        .o_ready     (byte_ready),
        .o_wr        (vram_wr),
        .o_bell      (bell)
    );

    text_vram vram0 (
        .i_clk       (i_clk),
        .i_wr        (vram_wr),
        .i_rd_addr   (rd_addr),
        .o_rd_data   (rd_data)
    );

    video_scan scan0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_reverse   (bell),
        .o_rd_addr   (rd_addr),
        .i_rd_data   (rd_data),
        .o_video     (o_video)
    );

endmodule

`default_nettype wire

// ==== rtl/text_vram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "term_config.svh"

module text_vram (
    input  wire                         i_clk,
    input  wire term_pkg::vram_wr_t     i_wr,        // From control block
    input  wire [`TERM_ADDR_BITS-1:0]   i_rd_addr,   // From scan engine
    output term_pkg::char_t             o_rd_data    // One clock after address
);

    import term_pkg::*;

    localparam int DEPTH = 1 << `TERM_ADDR_BITS;     // 2048 cells

    char_t mem [0:DEPTH-1];                          // Row-major, {row, col}

    // Write port, raw view of the address
    always_ff @(posedge i_clk) begin
        if (i_wr.we) begin
            mem[i_wr.addr.raw] <= i_wr.data;
        end
    end

    // Read port, registered for block RAM
    always_ff @(posedge i_clk) begin
        o_rd_data <= mem[i_rd_addr];                 // Old data on same-cell collision
    end

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "term_config.svh"

module uart_rx (
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire              i_rxd,                  // Async serial line, idle high
    output logic             o_valid,                // Byte waiting
    output term_pkg::char_t  o_data,                 // Received byte
    input  wire              i_ready                 // Consumer takes byte
);

    import term_pkg::*;

    localparam int CLKS     = `TERM_CLKS_PER_BIT;
    localparam int HALF_BIT = CLKS / 2;
    localparam int CNT_BITS = $clog2(CLKS);

    typedef enum logic [1:0] {
        RX_IDLE,                                     // Wait for falling edge
        RX_START,                                    // Run to middle of start bit
        RX_DATA,                                     // Eight data samples
        RX_STOP                                      // Stop bit sample
    } rx_state_t;

    rx_state_t           state;
    logic [1:0]          rxd_sync;                   // Two-flop synchronizer
    logic                rxd;                        // Synchronized line
    logic [CNT_BITS-1:0] clk_cnt;                    // Clocks within a bit
    logic [2:0]          bit_cnt;                    // Data bit index
    char_t               shift_reg;                  // LSB first
    logic                bit_end;                    // Sample point of a full bit

    assign rxd     = rxd_sync[1];
    assign bit_end = (clk_cnt == CNT_BITS'(CLKS - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rxd_sync <= 2'b11;                       // Line idles high
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            o_valid  <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], i_rxd};
            if (o_valid && i_ready) o_valid <= 1'b0; // Drop after handshake
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd) state <= RX_START;     // Low sample, maybe a start bit
                end
                RX_START: begin
                    if (clk_cnt == CNT_BITS'(HALF_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd ? RX_IDLE : RX_DATA; // Glitch goes back to idle
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    clk_cnt <= clk_cnt + 1'b1;       // Wraps to 0 at bit end
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_end) begin
                        state <= RX_IDLE;
                        if (rxd) o_valid <= 1'b1;    // Overrides a pending clear
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Payload path
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_end) shift_reg <= {rxd, shift_reg[7:1]};
        if (state == RX_STOP && bit_end && rxd) o_data <= shift_reg; // Overwrites old byte
    end

endmodule

`default_nettype wire

// ==== rtl/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // One cell of the raster stream, one per clock
    typedef struct packed {
        logic            hsync;                      // First blank cell of a line
        logic            vsync;                      // Blank lines at end of frame
        logic            den;                        // Active cell
        logic            reverse;                    // Bell, shown as inverted cell
        term_pkg::char_t code;                       // Character in this cell
    } video_cell_t;                                  // 12 bits

endpackage

`default_nettype wire

// ==== rtl/video_scan.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "term_config.svh"

module video_scan (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_reverse,   // Bell level
    output logic [`TERM_ADDR_BITS-1:0]  o_rd_addr,   // To VRAM
    input  wire term_pkg::char_t        i_rd_data,   // From VRAM, one clock late
    output video_pkg::video_cell_t      o_video
);

    import term_pkg::*;

    localparam int H_TOTAL = `TERM_COLS + `TERM_H_BLANK; // 72 cells
    localparam int V_TOTAL = `TERM_ROWS + `TERM_V_BLANK; // 34 lines
    localparam int H_BITS  = $clog2(H_TOTAL);
    localparam int V_BITS  = $clog2(V_TOTAL);

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic den;
        logic reverse;
    } timing_t;                                      // Cell timing before the code joins

    logic [H_BITS-1:0] h_cnt;                        // Cell in line
    logic [V_BITS-1:0] v_cnt;                        // Line in frame
    screen_addr_u      rd_pos;
    timing_t           stage1;                       // Timing, aligned with read

    assign rd_pos.pos.row = v_cnt[`TERM_ROW_BITS-1:0];
    assign rd_pos.pos.col = h_cnt[`TERM_COL_BITS-1:0];
    assign o_rd_addr      = rd_pos.raw;              // Junk during blanking, unused

    // Raster counters
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_BITS'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_BITS'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Two stages so den meets the VRAM data
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            stage1  <= '0;
            o_video <= '0;
        end else begin
            stage1.hsync   <= (h_cnt == H_BITS'(`TERM_COLS));  // First blank cell
            stage1.vsync   <= (v_cnt >= V_BITS'(`TERM_ROWS));  // Blank lines
            stage1.den     <= (h_cnt < H_BITS'(`TERM_COLS)) && (v_cnt < V_BITS'(`TERM_ROWS));
            stage1.reverse <= i_reverse;
            o_video.hsync  <= stage1.hsync;
            o_video.vsync  <= stage1.vsync;
            o_video.den    <= stage1.den;
            o_video.reverse <= stage1.reverse;
            o_video.code   <= stage1.den ? i_rd_data : '0;     // Zero outside active area
        end
    end

endmodule

`default_nettype wire

// ==== testbench/terminal_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "term_config.svh"

module terminal_tb;

    import term_pkg::*;
    import video_pkg::*;

    localparam int CPB       = `TERM_CLKS_PER_BIT;
    localparam int GAP       = 4;                    // Idle clocks after each byte
    localparam int CELLS     = `TERM_COLS * `TERM_ROWS;
    localparam int LINE_CYC  = `TERM_COLS + `TERM_H_BLANK;
    localparam int FRAME_CYC = LINE_CYC * (`TERM_ROWS + `TERM_V_BLANK);
    localparam int BYTE_CYC  = 10 * CPB + GAP;       // Start, 8 data, stop
    localparam int N_BYTES   = 330;                  // All tests, rounded up
    localparam int N_TESTS   = 6;
    localparam int LIMIT     = (N_BYTES * BYTE_CYC + 2 * (CELLS + 4)
                               + N_TESTS * (2 * FRAME_CYC + `TERM_BELL_CYCLES + 8)) * 5 / 4;

    logic        clk;
    logic        rst;
    logic        rxd;
    logic        show_ctrl;
    video_cell_t video;
    char_t       model_scr [0:CELLS-1];              // Expected screen, row-major
    int          cur_row;                            // Model cursor
    int          cur_col;
    int          cycles;
    int          test_errs;
    int          n_pass;
    int          n_fail;
    int          rev_run;                            // Reverse cells in current run
    int          rev_len;                            // Length of last finished run
    logic        frame_req;                          // Compare one frame, cleared when done
    logic [31:0] seed;
    string       test_name;

    terminal_top dut0 (
        .i_clk       (clk),
        .i_reset     (rst),
        .i_rxd       (rxd),
        .i_show_ctrl (show_ctrl),
        .o_video     (video)
    );

    bind terminal_top terminal_tb_asserts asserts0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_video     (o_video),
        .i_wr        (vram_wr),
        .i_valid     (byte_valid),
        .i_char      (byte_data),
        .i_ready     (byte_ready),
        .i_show_ctrl (i_show_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                       // 8 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (video.reverse) begin
            rev_run <= rev_run + 1;
        end else if (rev_run != 0) begin
            rev_len <= rev_run;                      // Run just ended
            rev_run <= 0;
        end
    end

    // Screen model, one byte at a time
    function automatic void model_byte(input char_t c);
        int i;
        if ((c >= CH_SPACE && c <= CH_TILDE) || show_ctrl) begin
            model_scr[cur_row * `TERM_COLS + cur_col] = c;
            cur_col = cur_col + 1;
            if (cur_col == `TERM_COLS) begin         // Wrap to next row
                cur_col = 0;
                cur_row = (cur_row + 1) % `TERM_ROWS;
            end
        end else begin
            case (c)
                CH_CR: cur_col = 0;
                CH_LF: cur_row = (cur_row + 1) % `TERM_ROWS;
                CH_BS: if (cur_col > 0) cur_col = cur_col - 1;
                CH_FF: begin
                    for (i = 0; i < CELLS; i++) model_scr[i] = CH_SPACE;
                    cur_row = 0;
                    cur_col = 0;
                end
                default: ;                           // BEL and others leave the screen
            endcase
        end
    endfunction

    task automatic send_byte(input char_t c);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, c, 1'b0};                      // Stop, data LSB first, start
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd <= bits[i];
            repeat (CPB - 1) @(posedge clk);
        end
        @(posedge clk);
        rxd <= 1'b1;
        repeat (GAP - 1) @(posedge clk);
        model_byte(c);
    endtask

    task automatic wait_clear();
        @(posedge clk);
        while (!dut0.byte_ready) @(posedge clk);     // Low through the sweep
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        repeat (`TERM_BELL_CYCLES + 8) @(posedge clk); // Bell window over
        frame_req = 1'b1;
        wait (!frame_req);
        $display("%s: %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
        if (test_errs == 0) n_pass++;
        else n_fail++;
    endtask

    // Frame compare, sampled on the falling edge
    initial begin
        int    line;
        int    col;
        int    cells;
        int    hpos;
        logic  prev_den;
        logic  exp_hs;
        char_t exp;
        forever begin
            wait (frame_req);
            do @(negedge clk); while (!video.vsync);
            do @(negedge clk); while (video.vsync);  // Now on cell 0,0
            line     = -1;
            col      = 0;
            cells    = 0;
            hpos     = 0;
            prev_den = 1'b0;
            while (cells < CELLS) begin
                exp_hs = (hpos == `TERM_COLS);       // First blank cell of a line
                assert (video.hsync == exp_hs) else begin
                    $display("Fail %s hsync line %0d cell %0d expected %b actual %b",
                             test_name, line, hpos, exp_hs, video.hsync);
                    test_errs++;
                end
                if (video.den) begin
                    if (!prev_den) begin             // New den line
                        line = line + 1;
                        col  = 0;
                    end
                    exp = model_scr[(line * `TERM_COLS + col) % CELLS];
                    assert (video.code == exp) else begin
                        $display("Fail %s cell %0d,%0d expected %h actual %h",
                                 test_name, line, col, exp, video.code);
                        test_errs++;
                    end
                    assert (video.reverse == 1'b0) else begin
                        $display("Fail %s cell %0d,%0d reverse expected 0 actual %b",
                                 test_name, line, col, video.reverse);
                        test_errs++;
                    end
                    col   = col + 1;
                    cells = cells + 1;
                end
                prev_den = video.den;
                hpos     = (hpos + 1) % LINE_CYC;
                if (cells < CELLS) @(negedge clk);
            end
            frame_req = 1'b0;
        end
    end

    initial begin
        int          i;
        logic [31:0] r;
        char_t       c;
        rst       = 1'b1;
        rxd       = 1'b1;
        show_ctrl = 1'b0;
        frame_req = 1'b0;
        cycles    = 0;
        rev_run   = 0;
        rev_len   = 0;
        n_pass    = 0;
        n_fail    = 0;
        cur_row   = 0;
        cur_col   = 0;
        seed      = 32'h939400dd;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        begin_test("ff_clear");
        send_byte(CH_FF);
        wait_clear();
        end_test();

        begin_test("print_wrap");                    // Past column 63 into row 1
        for (i = 0; i < 70; i++) send_byte(char_t'(8'h21 + i));
        end_test();

        begin_test("cursor_moves");
        send_byte(CH_FF);
        wait_clear();
        send_byte("x");
        send_byte(CH_BS);
        send_byte(CH_BS);                            // Already at column 0
        send_byte("y");
        send_byte(CH_CR);
        for (i = 0; i < 31; i++) send_byte(CH_LF);
        send_byte("z");                              // Row 31
        send_byte(CH_LF);                            // Back to row 0
        send_byte("w");
        end_test();

        begin_test("show_ctrl");
        @(posedge clk);
        show_ctrl <= 1'b1;
        send_byte(CH_CR);
        send_byte(CH_LF);
        send_byte(CH_BEL);
        @(posedge clk);
        show_ctrl <= 1'b0;
        send_byte(CH_CR);
        send_byte(CH_LF);
        send_byte(CH_BEL);
        send_byte("k");
        end_test();

        begin_test("bell");
        rev_len = 0;
        send_byte(CH_BEL);
        do @(negedge clk); while (video.reverse);
        repeat (2) @(negedge clk);                   // Run length settles
        assert (rev_len == `TERM_BELL_CYCLES) else begin
            $display("Fail %s reverse cycles expected %0d actual %0d",
                     test_name, `TERM_BELL_CYCLES, rev_len);
            test_errs++;
        end
        end_test();

        begin_test("random_stream");
        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            case (r[19:16])
                4'd0:    c = CH_CR;
                4'd1:    c = CH_LF;
                4'd2:    c = CH_BS;
                4'd3:    c = CH_BEL;
                4'd4:    c = 8'h01;                  // Ignored code
                default: c = CH_SPACE + char_t'(r[15:8] % 8'd95);
            endcase
            send_byte(c);
        end
        end_test();

        if (dut0.asserts0.n_errs != 0) begin
            $display("Bound assertions failed %0d times", dut0.asserts0.n_errs);
            n_fail++;
        end
        $display("Tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/terminal_tb_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "term_config.svh"

module terminal_tb_asserts (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire video_pkg::video_cell_t i_video,     // Raster stream at the top port
    input  wire term_pkg::vram_wr_t     i_wr,        // Control block write port
    input  wire                         i_valid,     // Character stream valid
    input  wire term_pkg::char_t        i_char,      // Character stream byte
    input  wire                         i_ready,     // Character stream ready
    input  wire                         i_show_ctrl  // Control codes stored as glyphs
);

    import term_pkg::*;

    localparam int CLEAR_CYC = 1 << `TERM_ADDR_BITS; // One write per cell

    int         n_errs;                              // Failed properties, read by the testbench
    logic [7:0] den_run;                             // Earlier den cells in this run
    int         clr_left;                            // Sweep clocks still to run

    initial n_errs = 0;

    always_ff @(posedge i_clk) begin
        if (i_reset || !i_video.den) begin
            den_run <= '0;
        end else begin
            den_run <= den_run + 1'b1;
        end
    end

    // FF taken as a command starts a sweep over every cell
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            clr_left <= 0;
        end else if (i_valid && i_ready && (i_char == CH_FF) && !i_show_ctrl) begin
            clr_left <= CLEAR_CYC;
        end else if (clr_left != 0) begin
            clr_left <= clr_left - 1;
        end
    end

    a_den_sync: assert property (@(posedge i_clk) disable iff (i_reset)
        i_video.den |-> !(i_video.hsync || i_video.vsync))
        else begin $error("den high together with a sync pulse"); n_errs++; end

    a_den_run: assert property (@(posedge i_clk) disable iff (i_reset)
        i_video.den |-> (int'(den_run) < `TERM_COLS))  // At most one row of cells
        else begin $error("den high for more than one row of cells"); n_errs++; end

    // Any known 11-bit index is a cell on the screen
    a_wr_range: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wr.we |-> !$isunknown(i_wr.addr))
        else begin $error("write strobe with an address off the screen"); n_errs++; end

    a_clear_ready: assert property (@(posedge i_clk) disable iff (i_reset)
        (clr_left != 0) |-> !i_ready)
        else begin $error("ready high while the screen clear runs"); n_errs++; end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/term_pkg.sv
rtl/video_pkg.sv
rtl/uart_rx.sv
rtl/term_control.sv
rtl/text_vram.sv
rtl/video_scan.sv
rtl/terminal_top.sv
testbench/terminal_tb_asserts.sv
testbench/terminal_tb.sv
